// File: cpu_control_unit.f
+incdir+.
cpu_ctrl_pkg.sv
instr_classifier.sv
ctrl_sequencer.sv
ctrl_encoder.sv
cpu_control_unit.sv
tb_cpu_control_unit.sv

// File: Bender.yml
package:
  name: cpu_control_unit

sources:
  - cpu_ctrl_pkg.sv
  - instr_classifier.sv
  - ctrl_sequencer.sv
  - ctrl_encoder.sv
  - cpu_control_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu_control_unit.sv

// File: ctrl_ref_model.svh
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

// Bit order: pc_write, mem_wr, ir_write, a_write, b_write,
// mdr_write, alu_reg_write, epc_write, reg_write
typedef logic [8:0] strobe_vec_t;

localparam strobe_vec_t STB_PC  = 9'b1_0000_0000;
localparam strobe_vec_t STB_IR  = 9'b0_0100_0000;
localparam strobe_vec_t STB_A   = 9'b0_0010_0000;
localparam strobe_vec_t STB_B   = 9'b0_0001_0000;
localparam strobe_vec_t STB_MDR = 9'b0_0000_1000;
localparam strobe_vec_t STB_ALU = 9'b0_0000_0100;
localparam strobe_vec_t STB_EPC = 9'b0_0000_0010;
localparam strobe_vec_t STB_REG = 9'b0_0000_0001;

// Expected state sequence of the current test, one entry per cycle
ctrl_state_e  exp_steps[$];
strobe_vec_t  exp_strobes;
iord_sel_e    exp_iord;
alu_src_a_e   exp_src_a;
alu_src_b_e   exp_src_b;
alu_op_e      exp_alu_op;
pc_src_e      exp_pc_src;
reg_dst_e     exp_reg_dst;
mem_to_reg_e  exp_mem_to_reg;
mdr_size_e    exp_mdr_size;
except_code_e exp_except;

function automatic bit traps_on_overflow(instr_class_e cls);
    return (cls == CLS_ADD) || (cls == CLS_SUB) || (cls == CLS_ADDI);
endfunction

function automatic bit is_load(instr_class_e cls);
    return (cls == CLS_LW) || (cls == CLS_LH) || (cls == CLS_LB);
endfunction

function automatic int expected_length(instr_class_e cls, logic ovl);
    int f;
    f = MEM_LATENCY + 3;
    if (cls == CLS_ILLEGAL) begin
        return f + EXC_WAIT_CYCLES + 1;
    end
    if (is_load(cls)) begin
        return f + 3 + MEM_LATENCY;
    end
    if (ovl && traps_on_overflow(cls)) begin
        return f + 1 + EXC_WAIT_CYCLES + 1;
    end
    return f + 2;
endfunction

function automatic void push_repeat(ctrl_state_e st, int n);
    for (int i = 0; i < n; i++) begin
        exp_steps.push_back(st);
    end
endfunction

// From decode up to and including the next instruction's latch
function automatic void build_steps(instr_class_e cls, logic ovl);
    ctrl_state_e exec_st;
    ctrl_state_e mdr_st;
    exec_st = ST_EXEC_ADD;
    mdr_st  = ST_MDR_WORD;
    case (cls)
        CLS_SUB: exec_st = ST_EXEC_SUB;
        CLS_AND: exec_st = ST_EXEC_AND;
        CLS_ADDI: exec_st = ST_EXEC_ADDI;
        CLS_ADDIU: exec_st = ST_EXEC_ADDIU;
        CLS_LH: mdr_st = ST_MDR_HALF;
        CLS_LB: mdr_st = ST_MDR_BYTE;
        default: begin
        end
    endcase
    exp_steps.delete();
    exp_steps.push_back(ST_DECODE);
    exp_steps.push_back(ST_DISPATCH);
    if (cls == CLS_ILLEGAL) begin
        push_repeat(ST_EXC_NOOP, EXC_WAIT_CYCLES);
        exp_steps.push_back(ST_EXC_COMMIT);
    end else if (is_load(cls)) begin
        exp_steps.push_back(ST_LOAD_ADDR);
        push_repeat(ST_LOAD_WAIT, MEM_LATENCY);
        exp_steps.push_back(mdr_st);
        exp_steps.push_back(ST_LOAD_WB);
    end else begin
        exp_steps.push_back(exec_st);
        if (ovl && traps_on_overflow(cls)) begin
            push_repeat(ST_EXC_OVF, EXC_WAIT_CYCLES);
            exp_steps.push_back(ST_EXC_COMMIT);
        end else if (cls == CLS_ADDI || cls == CLS_ADDIU) begin
            exp_steps.push_back(ST_WB_RT);
        end else begin
            exp_steps.push_back(ST_WB_RD);
        end
    end
    push_repeat(ST_FETCH_WAIT, MEM_LATENCY);
    exp_steps.push_back(ST_FETCH_LATCH);
endfunction

function automatic void set_expected(ctrl_state_e st);
    exp_strobes    = '0;
    exp_iord       = IORD_PC;
    exp_src_a      = SRC_A_PC;
    exp_src_b      = SRC_B_REG;
    exp_alu_op     = ALU_ADD;
    exp_pc_src     = PC_SRC_ALU;
    exp_reg_dst    = DST_RD;
    exp_mem_to_reg = WB_ALU;
    exp_mdr_size   = MDR_WORD;
    exp_except     = EXC_NOOPCODE;
    case (st)
        ST_FETCH_WAIT: exp_src_b = SRC_B_FOUR;
        ST_FETCH_LATCH: begin
            exp_src_b   = SRC_B_FOUR;
            exp_strobes = STB_PC | STB_IR;
        end
        ST_DECODE: begin
            exp_src_b   = SRC_B_FOUR;
            exp_strobes = STB_A | STB_B;
        end
        ST_EXEC_ADD, ST_EXEC_SUB, ST_EXEC_AND: begin
            exp_src_a   = SRC_A_REG;
            exp_strobes = STB_ALU;
            if (st == ST_EXEC_SUB) begin
                exp_alu_op = ALU_SUB;
            end else if (st == ST_EXEC_AND) begin
                exp_alu_op = ALU_AND;
            end
        end
        // Address computation of a load looks like an immediate add
        ST_EXEC_ADDI, ST_EXEC_ADDIU, ST_LOAD_ADDR: begin
            exp_src_a   = SRC_A_REG;
            exp_src_b   = SRC_B_IMM;
            exp_strobes = STB_ALU;
        end
        ST_WB_RD: exp_strobes = STB_REG;
        ST_WB_RT: begin
            exp_strobes = STB_REG;
            exp_reg_dst = DST_RT;
        end
        ST_LOAD_WAIT: exp_iord = IORD_ALU;
        ST_MDR_WORD, ST_MDR_HALF, ST_MDR_BYTE: begin
            exp_iord    = IORD_ALU;
            exp_strobes = STB_MDR;
            if (st == ST_MDR_HALF) begin
                exp_mdr_size = MDR_HALF;
            end else if (st == ST_MDR_BYTE) begin
                exp_mdr_size = MDR_BYTE;
            end
        end
        ST_LOAD_WB: begin
            exp_strobes    = STB_REG;
            exp_reg_dst    = DST_RT;
            exp_mem_to_reg = WB_MDR;
        end
        ST_EXC_NOOP, ST_EXC_OVF: begin
            exp_iord   = IORD_VECTOR;
            exp_src_b  = SRC_B_FOUR;
            exp_alu_op = ALU_SUB;
            if (st == ST_EXC_OVF) begin
                exp_except = EXC_OVERFLOW;
            end
        end
        ST_EXC_COMMIT: begin
            exp_src_b   = SRC_B_FOUR;
            exp_alu_op  = ALU_SUB;
            exp_strobes = STB_EPC | STB_PC;
            exp_pc_src  = PC_SRC_EXC;
        end
        default: begin
        end
    endcase
endfunction

function automatic string select_text(
    iord_sel_e s_iord, alu_src_a_e s_a, alu_src_b_e s_b, alu_op_e s_op, pc_src_e s_pc,
    reg_dst_e s_dst, mem_to_reg_e s_m2r, mdr_size_e s_mdr, except_code_e s_exc
);
    return $sformatf("%s %s %s %s %s %s %s %s %s", s_iord.name(), s_a.name(), s_b.name(),
        s_op.name(), s_pc.name(), s_dst.name(), s_m2r.name(), s_mdr.name(), s_exc.name());
endfunction

task automatic check_strobes(input string name, input strobe_vec_t exp_s, input strobe_vec_t act_s);
    check_count++;
    if (act_s !== exp_s) begin
        error_count++;
        $display("Mismatch %s strobes: expected %b actual %b", name, exp_s, act_s);
    end
endtask

task automatic check_selects(
    input string        name,
    input iord_sel_e    e_iord, a_iord,
    input alu_src_a_e   e_a, a_a,
    input alu_src_b_e   e_b, a_b,
    input alu_op_e      e_op, a_op,
    input pc_src_e      e_pc, a_pc,
    input reg_dst_e     e_dst, a_dst,
    input mem_to_reg_e  e_m2r, a_m2r,
    input mdr_size_e    e_mdr, a_mdr,
    input except_code_e e_exc, a_exc
);
    check_count++;
    if ({a_iord, a_a, a_b, a_op, a_pc, a_dst, a_m2r, a_mdr, a_exc} !==
        {e_iord, e_a, e_b, e_op, e_pc, e_dst, e_m2r, e_mdr, e_exc}) begin
        error_count++;
        $display("Mismatch %s selects: expected %s actual %s", name,
            select_text(e_iord, e_a, e_b, e_op, e_pc, e_dst, e_m2r, e_mdr, e_exc),
            select_text(a_iord, a_a, a_b, a_op, a_pc, a_dst, a_m2r, a_mdr, a_exc));
    end
endtask

task automatic check_length(input string name, input int exp_len, input int act_len);
    check_count++;
    if (act_len != exp_len) begin
        error_count++;
        $display("Mismatch %s length: expected %0d actual %0d", name, exp_len, act_len);
    end
endtask

`endif

// File: tb_cpu_control_unit.sv
`timescale 1ns/1ps

module tb_cpu_control_unit;
    import cpu_ctrl_pkg::*;

    localparam int MEM_LATENCY     = 2;
    localparam int EXC_WAIT_CYCLES = 8;
    localparam int NUM_INSTR       = 300;
    localparam int LOAD_LEN        = 2 * MEM_LATENCY + 6;
    localparam int OVF_LEN         = MEM_LATENCY + 5 + EXC_WAIT_CYCLES;
    localparam int LONGEST_LEN     = (LOAD_LEN > OVF_LEN) ? LOAD_LEN : OVF_LEN;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * LONGEST_LEN + 100;

    logic         clk;
    logic         reset;
    logic         ov;
    opcode_t      opcode;
    funct_t       funct;
    logic         pc_write, mem_wr, ir_write;
    logic         a_write, b_write, mdr_write;
    logic         alu_reg_write, epc_write, reg_write;
    iord_sel_e    iord;
    alu_src_a_e   alu_src_a;
    alu_src_b_e   alu_src_b;
    alu_op_e      alu_op;
    pc_src_e      pc_src;
    reg_dst_e     reg_dst;
    mem_to_reg_e  mem_to_reg;
    mdr_size_e    mem_to_mdr;
    except_code_e except_code;

    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;
    int fail_count  = 0;

    `include "ctrl_ref_model.svh"

    cpu_control_unit #(
        .MEM_LATENCY     (MEM_LATENCY),
        .EXC_WAIT_CYCLES (EXC_WAIT_CYCLES)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the control unit stopped issuing instructions after %0d cycles",
            WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic bit is_kept_opcode(opcode_t op);
        return (op == OP_RTYPE) || (op == OP_ADDI) || (op == OP_ADDIU) ||
            (op == OP_LW) || (op == OP_LH) || (op == OP_LB);
    endfunction

    // 10% per kept class, the rest split between bad funct and bad opcode
    task automatic pick_instruction(output instr_class_e cls, output opcode_t op, output funct_t fn);
        int r;
        r   = $urandom_range(0, 99);
        op  = OP_RTYPE;
        fn  = funct_t'($urandom_range(0, 63));
        cls = (r < 80) ? instr_class_e'(r / 10) : CLS_ILLEGAL;
        case (cls)
            CLS_ADD: fn = FN_ADD;
            CLS_SUB: fn = FN_SUB;
            CLS_AND: fn = FN_AND;
            CLS_ADDI: op = OP_ADDI;
            CLS_ADDIU: op = OP_ADDIU;
            CLS_LW: op = OP_LW;
            CLS_LH: op = OP_LH;
            CLS_LB: op = OP_LB;
            default: begin
                if (r < 90) begin
                    while (fn == FN_ADD || fn == FN_SUB || fn == FN_AND) begin
                        fn = funct_t'($urandom_range(0, 63));
                    end
                end else begin
                    op = opcode_t'($urandom_range(0, 63));
                    while (is_kept_opcode(op)) begin
                        op = opcode_t'($urandom_range(0, 63));
                    end
                end
            end
        endcase
    endtask

    // Walks exp_steps one cycle at a time, length runs to the next ir_write
    task automatic run_test(input string name, input int exp_len, input int len_offset);
        int    first_ir;
        int    errs_before;
        string tag;
        first_ir    = -1;
        errs_before = error_count;
        for (int k = 0; k < exp_steps.size(); k++) begin
            tag = $sformatf("%s cycle %0d", name, k);
            set_expected(exp_steps[k]);
            check_strobes(tag, exp_strobes, {pc_write, mem_wr, ir_write, a_write, b_write,
                mdr_write, alu_reg_write, epc_write, reg_write});
            check_selects(tag, exp_iord, iord, exp_src_a, alu_src_a, exp_src_b, alu_src_b,
                exp_alu_op, alu_op, exp_pc_src, pc_src, exp_reg_dst, reg_dst,
                exp_mem_to_reg, mem_to_reg, exp_mdr_size, mem_to_mdr, exp_except, except_code);
            if (ir_write === 1'b1 && first_ir < 0) begin
                first_ir = k;
            end
            next_cycle();
        end
        if (first_ir < 0) begin
            error_count++;
            $display("%s: the control unit never raised ir_write for the next fetch", name);
        end else begin
            check_length(name, exp_len, first_ir + len_offset);
        end
        test_count++;
        if (error_count != errs_before) begin
            fail_count++;
        end
        $display("%s: %s", name, (error_count == errs_before) ? "pass" : "fail");
    endtask

    initial begin
        instr_class_e cls;
        opcode_t      op;
        funct_t       fn;
        logic         ovl;
        void'($urandom(32'h3d1a_82b8));
        reset  = 1'b1;
        ov     = 1'b0;
        opcode = '0;
        funct  = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // First fetch, ir_write expected MEM_LATENCY cycles after reset falls
        exp_steps.delete();
        push_repeat(ST_FETCH_WAIT, MEM_LATENCY);
        exp_steps.push_back(ST_FETCH_LATCH);
        run_test("reset_fetch", MEM_LATENCY, 0);

        for (int i = 0; i < NUM_INSTR; i++) begin
            pick_instruction(cls, op, fn);
            ovl    = ($urandom_range(0, 2) == 0);
            opcode = op;
            funct  = fn;
            ov     = ovl;
            build_steps(cls, ovl);
            run_test($sformatf("i%03d_%s_op%02h_fn%02h_ov%0d", i, cls.name(), op, fn, ovl),
                expected_length(cls, ovl), 1);
        end

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
            test_count, fail_count, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: cpu_control_unit.sv
`timescale 1ns/1ps

module cpu_control_unit #(
    parameter int MEM_LATENCY     = 2,
    parameter int EXC_WAIT_CYCLES = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ov,
    input  cpu_ctrl_pkg::opcode_t      opcode,
    input  cpu_ctrl_pkg::funct_t       funct,
    output logic                       pc_write,
    output logic                       mem_wr,
    output logic                       ir_write,
    output logic                       a_write,
    output logic                       b_write,
    output logic                       mdr_write,
    output logic                       alu_reg_write,
    output logic                       epc_write,
    output logic                       reg_write,
    output cpu_ctrl_pkg::iord_sel_e    iord,
    output cpu_ctrl_pkg::alu_src_a_e   alu_src_a,
    output cpu_ctrl_pkg::alu_src_b_e   alu_src_b,
    output cpu_ctrl_pkg::alu_op_e      alu_op,
    output cpu_ctrl_pkg::pc_src_e      pc_src,
    output cpu_ctrl_pkg::reg_dst_e     reg_dst,
    output cpu_ctrl_pkg::mem_to_reg_e  mem_to_reg,
    output cpu_ctrl_pkg::mdr_size_e    mem_to_mdr,
    output cpu_ctrl_pkg::except_code_e except_code
);
    import cpu_ctrl_pkg::*;

    instr_class_e instr_class;
    ctrl_state_e  state;

    instr_classifier u_classifier (
        .opcode      (opcode),
        .funct       (funct),
        .instr_class (instr_class)
    );

    ctrl_sequencer #(
        .MEM_LATENCY     (MEM_LATENCY),
        .EXC_WAIT_CYCLES (EXC_WAIT_CYCLES)
    ) u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .ov          (ov),
        .state       (state)
    );

    ctrl_encoder u_encoder (
        .state         (state),
        .pc_write      (pc_write),
        .mem_wr        (mem_wr),
        .ir_write      (ir_write),
        .a_write       (a_write),
        .b_write       (b_write),
        .mdr_write     (mdr_write),
        .alu_reg_write (alu_reg_write),
        .epc_write     (epc_write),
        .reg_write     (reg_write),
        .iord          (iord),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .pc_src        (pc_src),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .mem_to_mdr    (mem_to_mdr),
        .except_code   (except_code)
    );

endmodule

// File: ctrl_encoder.sv
`timescale 1ns/1ps

module ctrl_encoder (
    input  cpu_ctrl_pkg::ctrl_state_e  state,
    output logic                       pc_write,
    output logic                       mem_wr,
    output logic                       ir_write,
    output logic                       a_write,
    output logic                       b_write,
    output logic                       mdr_write,
    output logic                       alu_reg_write,
    output logic                       epc_write,
    output logic                       reg_write,
    output cpu_ctrl_pkg::iord_sel_e    iord,
    output cpu_ctrl_pkg::alu_src_a_e   alu_src_a,
    output cpu_ctrl_pkg::alu_src_b_e   alu_src_b,
    output cpu_ctrl_pkg::alu_op_e      alu_op,
    output cpu_ctrl_pkg::pc_src_e      pc_src,
    output cpu_ctrl_pkg::reg_dst_e     reg_dst,
    output cpu_ctrl_pkg::mem_to_reg_e  mem_to_reg,
    output cpu_ctrl_pkg::mdr_size_e    mem_to_mdr,
    output cpu_ctrl_pkg::except_code_e except_code
);
    import cpu_ctrl_pkg::*;

    always_comb begin
        pc_write      = 1'b0;
        mem_wr        = 1'b0;
        ir_write      = 1'b0;
        a_write       = 1'b0;
        b_write       = 1'b0;
        mdr_write     = 1'b0;
        alu_reg_write = 1'b0;
        epc_write     = 1'b0;
        reg_write     = 1'b0;
        iord          = IORD_PC;
        alu_src_a     = SRC_A_PC;
        alu_src_b     = SRC_B_REG;
        alu_op        = ALU_ADD;
        pc_src        = PC_SRC_ALU;
        reg_dst       = DST_RD;
        mem_to_reg    = WB_ALU;
        mem_to_mdr    = MDR_WORD;
        except_code   = EXC_NOOPCODE;

        case (state)
            // PC + 4 on the ALU while the fetch is pending
            ST_FETCH_WAIT: begin
                alu_src_b = SRC_B_FOUR;
            end
            ST_FETCH_LATCH: begin
                alu_src_b = SRC_B_FOUR;
                pc_write  = 1'b1;
                ir_write  = 1'b1;
            end
            ST_DECODE: begin
                alu_src_b = SRC_B_FOUR;
                a_write   = 1'b1;
                b_write   = 1'b1;
            end
            ST_EXEC_ADD, ST_EXEC_SUB, ST_EXEC_AND: begin
                alu_src_a     = SRC_A_REG;
                alu_src_b     = SRC_B_REG;
                alu_reg_write = 1'b1;
                if (state == ST_EXEC_SUB) begin
                    alu_op = ALU_SUB;
                end else if (state == ST_EXEC_AND) begin
                    alu_op = ALU_AND;
                end
            end
            ST_EXEC_ADDI, ST_EXEC_ADDIU: begin
                alu_src_a     = SRC_A_REG;
                alu_src_b     = SRC_B_IMM;
                alu_reg_write = 1'b1;
            end
            ST_WB_RD: begin
                reg_write = 1'b1;
            end
            ST_WB_RT: begin
                reg_write = 1'b1;
                reg_dst   = DST_RT;
            end
            // Base plus offset, kept in the ALU register for the read
            ST_LOAD_ADDR: begin
                alu_src_a     = SRC_A_REG;
                alu_src_b     = SRC_B_IMM;
                alu_reg_write = 1'b1;
            end
            ST_LOAD_WAIT: begin
                iord = IORD_ALU;
            end
            ST_MDR_WORD, ST_MDR_HALF, ST_MDR_BYTE: begin
                iord      = IORD_ALU;
                mdr_write = 1'b1;
                if (state == ST_MDR_HALF) begin
                    mem_to_mdr = MDR_HALF;
                end else if (state == ST_MDR_BYTE) begin
                    mem_to_mdr = MDR_BYTE;
                end
            end
            ST_LOAD_WB: begin
                reg_write  = 1'b1;
                reg_dst    = DST_RT;
                mem_to_reg = WB_MDR;
            end
            // Vector read, ALU rewinds PC to the faulting instruction
            ST_EXC_NOOP, ST_EXC_OVF: begin
                iord      = IORD_VECTOR;
                alu_src_b = SRC_B_FOUR;
                alu_op    = ALU_SUB;
                if (state == ST_EXC_OVF) begin
                    except_code = EXC_OVERFLOW;
                end
            end
            ST_EXC_COMMIT: begin
                alu_src_b = SRC_B_FOUR;
                alu_op    = ALU_SUB;
                epc_write = 1'b1;
                pc_write  = 1'b1;
                pc_src    = PC_SRC_EXC;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: ctrl_sequencer.sv
`timescale 1ns/1ps

module ctrl_sequencer #(
    parameter int MEM_LATENCY     = 2,
    parameter int EXC_WAIT_CYCLES = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  cpu_ctrl_pkg::instr_class_e instr_class,
    input  logic                       ov,
    output cpu_ctrl_pkg::ctrl_state_e  state
);
    import cpu_ctrl_pkg::*;

    localparam int WAIT_MAX = (MEM_LATENCY > EXC_WAIT_CYCLES) ? MEM_LATENCY : EXC_WAIT_CYCLES;
    localparam int CNT_W = (WAIT_MAX > 1) ? $clog2(WAIT_MAX) : 1;

    // Last count of each waiting state
    localparam logic [CNT_W-1:0] MEM_LAST = CNT_W'(MEM_LATENCY - 1);
    localparam logic [CNT_W-1:0] EXC_LAST = CNT_W'(EXC_WAIT_CYCLES - 1);

    ctrl_state_e      state_next;
    ctrl_state_e      load_mdr_state;
    logic [CNT_W-1:0] wait_cnt;
    logic             mem_done;
    logic             exc_done;

    assign mem_done = (wait_cnt == MEM_LAST);
    assign exc_done = (wait_cnt == EXC_LAST);

    always_comb begin
        state_next = state;
        case (state)
            ST_FETCH_WAIT: begin
                if (mem_done) begin
                    state_next = ST_FETCH_LATCH;
                end
            end
            ST_FETCH_LATCH: begin
                state_next = ST_DECODE;
            end
            ST_DECODE: begin
                state_next = ST_DISPATCH;
            end
            ST_DISPATCH: begin
                case (instr_class)
                    CLS_ADD: state_next = ST_EXEC_ADD;
                    CLS_SUB: state_next = ST_EXEC_SUB;
                    CLS_AND: state_next = ST_EXEC_AND;
                    CLS_ADDI: state_next = ST_EXEC_ADDI;
                    CLS_ADDIU: state_next = ST_EXEC_ADDIU;
                    CLS_LW, CLS_LH, CLS_LB: state_next = ST_LOAD_ADDR;
                    default: state_next = ST_EXC_NOOP;
                endcase
            end
            // Signed ops trap on overflow, and and addiu never do
            ST_EXEC_ADD, ST_EXEC_SUB: begin
                state_next = ov ? ST_EXC_OVF : ST_WB_RD;
            end
            ST_EXEC_AND: begin
                state_next = ST_WB_RD;
            end
            ST_EXEC_ADDI: begin
                state_next = ov ? ST_EXC_OVF : ST_WB_RT;
            end
            ST_EXEC_ADDIU: begin
                state_next = ST_WB_RT;
            end
            ST_WB_RD, ST_WB_RT, ST_LOAD_WB, ST_EXC_COMMIT: begin
                state_next = ST_FETCH_WAIT;
            end
            ST_LOAD_ADDR: begin
                state_next = ST_LOAD_WAIT;
            end
            ST_LOAD_WAIT: begin
                if (mem_done) begin
                    state_next = load_mdr_state;
                end
            end
            ST_MDR_WORD, ST_MDR_HALF, ST_MDR_BYTE: begin
                state_next = ST_LOAD_WB;
            end
            ST_EXC_NOOP, ST_EXC_OVF: begin
                if (exc_done) begin
                    state_next = ST_EXC_COMMIT;
                end
            end
            default: begin
                state_next = ST_FETCH_WAIT;
            end
        endcase
    end

    // Wait counter restarts whenever the state changes
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_FETCH_WAIT;
            wait_cnt <= '0;
        end else begin
            state <= state_next;
            if (state_next != state) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // Load size picked at dispatch, used when the memory wait ends
    always_ff @(posedge clk) begin
        if (state == ST_DISPATCH) begin
            case (instr_class)
                CLS_LH: load_mdr_state <= ST_MDR_HALF;
                CLS_LB: load_mdr_state <= ST_MDR_BYTE;
                default: load_mdr_state <= ST_MDR_WORD;
            endcase
        end
    end

endmodule

// File: instr_classifier.sv
`timescale 1ns/1ps

module instr_classifier (
    input  cpu_ctrl_pkg::opcode_t      opcode,
    input  cpu_ctrl_pkg::funct_t       funct,
    output cpu_ctrl_pkg::instr_class_e instr_class
);
    import cpu_ctrl_pkg::*;

    always_comb begin
        instr_class = CLS_ILLEGAL;
        case (opcode)
            OP_RTYPE: begin
                // Only add, sub and and are decoded
                case (funct)
                    FN_ADD: instr_class = CLS_ADD;
                    FN_SUB: instr_class = CLS_SUB;
                    FN_AND: instr_class = CLS_AND;
                    default: instr_class = CLS_ILLEGAL;
                endcase
            end
            OP_ADDI: begin
                instr_class = CLS_ADDI;
            end
            OP_ADDIU: begin
                instr_class = CLS_ADDIU;
            end
            OP_LW: begin
                instr_class = CLS_LW;
            end
            OP_LH: begin
                instr_class = CLS_LH;
            end
            OP_LB: begin
                instr_class = CLS_LB;
            end
            default: begin
                instr_class = CLS_ILLEGAL;
            end
        endcase
    end

endmodule

// File: cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // Instruction register fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_LB    = 6'h20;
    localparam opcode_t OP_LH    = 6'h21;
    localparam opcode_t OP_LW    = 6'h23;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;

    typedef enum logic [3:0] {
        CLS_ADD,
        CLS_SUB,
        CLS_AND,
        CLS_ADDI,
        CLS_ADDIU,
        CLS_LW,
        CLS_LH,
        CLS_LB,
        CLS_ILLEGAL
    } instr_class_e;

    typedef enum logic [4:0] {
        ST_FETCH_WAIT,
        ST_FETCH_LATCH,
        ST_DECODE,
        ST_DISPATCH,
        ST_EXEC_ADD,
        ST_EXEC_SUB,
        ST_EXEC_AND,
        ST_EXEC_ADDI,
        ST_EXEC_ADDIU,
        ST_WB_RD,
        ST_WB_RT,
        ST_LOAD_ADDR,
        ST_LOAD_WAIT,
        ST_MDR_WORD,
        ST_MDR_HALF,
        ST_MDR_BYTE,
        ST_LOAD_WB,
        ST_EXC_NOOP,
        ST_EXC_OVF,
        ST_EXC_COMMIT
    } ctrl_state_e;

    // Datapath multiplexer selects
    typedef enum logic [1:0] {IORD_PC = 2'd0, IORD_ALU = 2'd1, IORD_VECTOR = 2'd2} iord_sel_e;

    typedef enum logic {SRC_A_PC = 1'b0, SRC_A_REG = 1'b1} alu_src_a_e;

    typedef enum logic [1:0] {SRC_B_REG = 2'd0, SRC_B_FOUR = 2'd1, SRC_B_IMM = 2'd2} alu_src_b_e;

    // Same codes as the datapath ALU, zero is unused
    typedef enum logic [1:0] {ALU_ADD = 2'd1, ALU_AND = 2'd2, ALU_SUB = 2'd3} alu_op_e;

    typedef enum logic {PC_SRC_ALU = 1'b0, PC_SRC_EXC = 1'b1} pc_src_e;

    typedef enum logic {DST_RD = 1'b0, DST_RT = 1'b1} reg_dst_e;

    typedef enum logic {WB_ALU = 1'b0, WB_MDR = 1'b1} mem_to_reg_e;

    typedef enum logic [1:0] {MDR_WORD = 2'd0, MDR_HALF = 2'd1, MDR_BYTE = 2'd2} mdr_size_e;

    typedef enum logic {EXC_NOOPCODE = 1'b0, EXC_OVERFLOW = 1'b1} except_code_e;

endpackage
